// File: testbench/pl_cfg_stimulus.txt
# W addr data | R addr expect | X dev_addr dev_data | G min_gap | M silent
# D expected_status | S cfg_up dsp_up max_cycles ; every field is hex
W 008 deadbeef
R 008 deadbeef
W 00c 12345678
R 00c 00000000
R 200 00000000
R 140 00000000
W 100 4012a5a5
W 104 40340001
W 108 80000028
W 10c 4056beef
W 110 00000000
R 100 4012a5a5
R 10c 4056beef
X 12 a5a5
X 34 0001
G 28
X 56 beef
W 000 00000001
R 000 00000000
D 00000042
S 1 1 13
W 000 00000004
R 000 00000004
S 1 0 3
W 000 00000002
S 0 0 3
W 000 00000000
S 1 1 28
M 1
W 100 80000003
W 104 40771234
X 77 1234
W 000 00000001
D 00000014
S 1 0 3
M 0
X 77 1234
G 28
X 56 beef
W 000 00000001
D 00000042
S 1 1 13

// File: filelist.f
rtl/pl_cfg_pkg.sv
rtl/settle_timer.sv
rtl/reset_fanout.sv
rtl/cfg_step_table.sv
rtl/lb_cfg_regs.sv
rtl/cfg_sequencer.sv
rtl/pl_cfg_top.sv
testbench/tb_pl_cfg_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the configuration plane testbench with verilator and run it

if ! cd "$(dirname "$0")"; then
	echo "cannot enter the project root"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module tb_pl_cfg_top \
	--Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_sim 2>&1)
sim_rc=$?
printf '%s\n' "$sim_out"

if [ $sim_rc -ne 0 ]; then
	echo "simulation exited with status $sim_rc"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'STATUS: PASS'; then
	exit 0
fi
echo "pass line not found in the simulation output"
exit 1

// File: testbench/tb_pl_cfg_top.sv
// testbench for the configuration plane, file driven bus traffic and a req/ack device model.
`timescale 1ns/1ps

module tb_pl_cfg_top import pl_cfg_pkg::*; ();

	localparam int ACK_TIMEOUT = 64;
	localparam int RESET_HOLD  = 16;
	localparam int CFG_W       = 128;
	localparam int DSP_W       = 32;
	// two bus cycles per status poll.
	localparam int DONE_POLLS  = 500;

	logic             cfgclk = 1'b0;
	logic             rst_n;
	lb_req_t          lb_req;
	lb_rsp_t          lb_rsp;
	logic             dev_req;
	dev_xfer_t        dev_xfer;
	logic             dev_ack = 1'b0;
	logic [CFG_W-1:0] cfg_resetn;
	logic [DSP_W-1:0] dsp_resetn;

	// device model state.
	dev_xfer_t exp_xfer [$];
	int        exp_gap [$];
	int        gap_next = 0;
	int        cycle = 0;
	int        last_rise = 0;
	int        ack_delay = 0;
	logic      req_q = 1'b0;
	dev_xfer_t xfer_q;
	dev_xfer_t want;
	int        gap;
	bit        silent = 1'b0;
	// set once a sequence has finished with done.
	bit        seq_ok = 1'b0;

	pl_cfg_top #(
		.ACK_TIMEOUT(ACK_TIMEOUT),
		.RESET_HOLD(RESET_HOLD),
		.CFG_RESET_WIDTH(CFG_W),
		.DSP_RESET_WIDTH(DSP_W)
	) uut (
		.cfgclk(cfgclk), .rst_n(rst_n), .lb_req(lb_req), .lb_rsp(lb_rsp),
		.dev_req(dev_req), .dev_xfer(dev_xfer), .dev_ack(dev_ack),
		.cfg_resetn(cfg_resetn), .dsp_resetn(dsp_resetn)
	);

	// 100 ns clock.
	always #50 cfgclk = ~cfgclk;

	// ******************************
	// failure reporting
	// ******************************

	task automatic end_failed();
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		$display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
		end_failed();
	endtask

	task automatic abort_run(input string why);
		$display("ERROR: %s", why);
		end_failed();
	endtask

	// ******************************
	// bus helpers
	// ******************************

	// one cycle, inputs change 1 ns after the edge.
	task automatic tick();
		@(posedge cfgclk);
		#1;
	endtask

	task automatic bus_write(input logic [9:0] addr, input logic [31:0] data);
		lb_req.wr    = 1'b1;
		lb_req.rd    = 1'b0;
		lb_req.addr  = addr;
		lb_req.wdata = data;
		tick();
		lb_req.wr = 1'b0;
	endtask

	// rvalid must be high for exactly the cycle after the strobe.
	task automatic bus_read(input logic [9:0] addr, output logic [31:0] data);
		lb_req.wr   = 1'b0;
		lb_req.rd   = 1'b1;
		lb_req.addr = addr;
		tick();
		lb_req.rd = 1'b0;
		assert (lb_rsp.rvalid == 1'b1) else report_mismatch("lb_rsp.rvalid", lb_rsp.rvalid, 1);
		data = lb_rsp.rdata;
		tick();
		assert (lb_rsp.rvalid == 1'b0) else report_mismatch("lb_rsp.rvalid", lb_rsp.rvalid, 0);
	endtask

	// ******************************
	// waits
	// ******************************

	task automatic wait_resets(input bit cfg_up, input bit dsp_up, input int limit);
		logic [CFG_W-1:0] cfg_exp;
		logic [DSP_W-1:0] dsp_exp;
		bit               hit;
		cfg_exp = cfg_up ? '1 : '0;
		dsp_exp = dsp_up ? '1 : '0;
		hit = (cfg_resetn == cfg_exp) && (dsp_resetn == dsp_exp);
		for (int i = 0; i < limit && !hit; i++) begin
			tick();
			hit = (cfg_resetn == cfg_exp) && (dsp_resetn == dsp_exp);
		end
		assert (hit) else abort_run($sformatf(
			"reset outputs not at cfg=%0d dsp=%0d within %0d cycles", cfg_up, dsp_up, limit));
	endtask

	// busy rises two cycles after the start write, so skip those first.
	task automatic wait_done(input logic [31:0] exp);
		logic [31:0] st;
		bit          fin;
		st  = '0;
		fin = 1'b0;
		tick();
		tick();
		for (int i = 0; i < DONE_POLLS && !fin; i++) begin
			bus_read(REG_STATUS, st);
			fin = !st[0] && (st[1] || st[2]);
		end
		assert (fin) else abort_run("sequence did not finish before the poll limit");
		assert (st == exp) else report_mismatch("status", st, exp);
		assert (dev_req == 1'b0) else report_mismatch("dev_req", dev_req, 0);
		assert (exp_xfer.size() == 0) else abort_run("expected device writes were never seen");
		if (st[1]) begin
			seq_ok = 1'b1;
		end
	endtask

	// one stimulus line.
	task automatic run_command(input byte cmd, input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] c);
		logic [31:0] rd;
		case (cmd)
			"W": bus_write(a[9:0], b);
			"R": begin
				bus_read(a[9:0], rd);
				assert (rd == b) else report_mismatch(
					$sformatf("lb_rsp.rdata at 0x%03h", a[9:0]), rd, b);
			end
			"X": begin
				exp_xfer.push_back('{dev_addr: a[7:0], dev_data: b[15:0]});
				exp_gap.push_back(gap_next);
				gap_next = 0;
			end
			"G": gap_next = int'(a);
			"M": silent = a[0];
			"D": wait_done(a);
			"S": wait_resets(a[0], b[0], int'(c));
			default: abort_run($sformatf("unknown stimulus command '%c'", cmd));
		endcase
	endtask

	// ******************************
	// main sequence
	// ******************************

	initial begin
		int          fd;
		string       line;
		byte         cmd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		rst_n  = 1'b0;
		lb_req = '0;
		for (int i = 0; i < 8; i++) begin
			tick();
			assert (cfg_resetn == '0) else report_mismatch("cfg_resetn", cfg_resetn, 0);
			assert (dsp_resetn == '0) else report_mismatch("dsp_resetn", dsp_resetn, 0);
			assert (dev_req == 1'b0) else report_mismatch("dev_req", dev_req, 0);
		end
		rst_n = 1'b1;
		tick();
		// hold counter still running.
		assert (cfg_resetn == '0) else report_mismatch("cfg_resetn", cfg_resetn, 0);
		wait_resets(1'b1, 1'b0, RESET_HOLD + 2);

		fd = $fopen("testbench/pl_cfg_stimulus.txt", "r");
		assert (fd != 0) else abort_run("cannot open the stimulus file");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.getc(0) != "#") begin
				cmd = line.getc(0);
				a   = '0;
				b   = '0;
				c   = '0;
				void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
				run_command(cmd, a, b, c);
			end
		end
		$fclose(fd);
		assert (exp_xfer.size() == 0) else abort_run("device writes left over at the end");
		$display("STATUS: PASS");
		$finish;
	end

	// ******************************
	// device model and port checks
	// ******************************

	// samples 1 ns after each edge, ack drives in the same step.
	initial begin
		void'($urandom(32'hf480_1423));
		forever begin
			tick();
			cycle++;
			if (!seq_ok) begin
				assert (dsp_resetn == '0) else report_mismatch("dsp_resetn", dsp_resetn, 0);
			end
			if (dev_req && !req_q) begin
				assert (dev_ack == 1'b0) else abort_run("dev_req rose while dev_ack was high");
				assert (exp_xfer.size() != 0) else abort_run("dev_req rose with no write expected");
				want = exp_xfer.pop_front();
				gap  = exp_gap.pop_front();
				assert (dev_xfer == want) else report_mismatch("dev_xfer", dev_xfer, want);
				assert (cycle - last_rise >= gap) else abort_run($sformatf(
					"dev_req rose %0d cycles after the last one, at least %0d needed",
					cycle - last_rise, gap));
				last_rise = cycle;
				if (!silent) begin
					ack_delay = 1 + int'($urandom % 5);
				end
			end else if (dev_req && req_q) begin
				assert (dev_xfer == xfer_q) else report_mismatch("dev_xfer", dev_xfer, xfer_q);
			end else if (!dev_req && req_q && dev_ack) begin
				// release phase.
				ack_delay = 1 + int'($urandom % 5);
			end
			if (ack_delay > 0) begin
				ack_delay--;
				if (ack_delay == 0) begin
					dev_ack = !dev_ack;
				end
			end
			req_q  = dev_req;
			xfer_q = dev_xfer;
		end
	end

endmodule

// File: rtl/pl_cfg_top.sv
// configuration plane top, local bus registers, step sequencer and reset fanout.
`timescale 1ns/1ps

module pl_cfg_top import pl_cfg_pkg::*; #(
	parameter int ACK_TIMEOUT     = 64,
	parameter int RESET_HOLD      = 16,
	parameter int CFG_RESET_WIDTH = 128,
	parameter int DSP_RESET_WIDTH = 32
) (
	input  logic                       cfgclk,
	input  logic                       rst_n,
	input  lb_req_t                    lb_req,
	output lb_rsp_t                    lb_rsp,
	output logic                       dev_req,
	output dev_xfer_t                  dev_xfer,
	input  logic                       dev_ack,
	output logic [CFG_RESET_WIDTH-1:0] cfg_resetn,
	output logic [DSP_RESET_WIDTH-1:0] dsp_resetn
);

	// ******************************
	// internal nets
	// ******************************

	cfg_status_t status;
	logic        start;
	logic        cfg_soft_rst;
	logic        dsp_rst_req;
	logic        tbl_we;
	logic [3:0]  tbl_widx;
	cfg_step_t   tbl_wdata;
	logic [3:0]  tbl_ridx;
	cfg_step_t   tbl_rdata;
	logic [3:0]  step_ridx;
	cfg_step_t   step;
	logic        tmr_load;
	logic [15:0] tmr_count;
	logic        tmr_expired;

	// host register block.
	lb_cfg_regs regs (
		.cfgclk(cfgclk), .rst_n(rst_n), .lb_req(lb_req), .lb_rsp(lb_rsp),
		.status(status), .start(start), .cfg_soft_rst(cfg_soft_rst),
		.dsp_rst_req(dsp_rst_req), .tbl_we(tbl_we), .tbl_widx(tbl_widx),
		.tbl_wdata(tbl_wdata), .tbl_ridx(tbl_ridx), .tbl_rdata(tbl_rdata)
	);

	cfg_step_table table_i (
		.cfgclk(cfgclk), .we(tbl_we), .widx(tbl_widx), .wdata(tbl_wdata),
		.bus_ridx(tbl_ridx), .bus_rdata(tbl_rdata),
		.seq_ridx(step_ridx), .seq_rdata(step)
	);

	cfg_sequencer #(.ACK_TIMEOUT(ACK_TIMEOUT)) seq (
		.cfgclk(cfgclk), .rst_n(rst_n), .start(start),
		.step_ridx(step_ridx), .step(step),
		.tmr_load(tmr_load), .tmr_count(tmr_count), .tmr_expired(tmr_expired),
		.dev_req(dev_req), .dev_xfer(dev_xfer), .dev_ack(dev_ack),
		.status(status)
	);

	// shared by delay and ack waits.
	settle_timer timer (
		.cfgclk(cfgclk), .rst_n(rst_n), .load(tmr_load),
		.count(tmr_count), .expired(tmr_expired)
	);

	reset_fanout #(
		.RESET_HOLD(RESET_HOLD),
		.CFG_RESET_WIDTH(CFG_RESET_WIDTH),
		.DSP_RESET_WIDTH(DSP_RESET_WIDTH)
	) rstgen (
		.cfgclk(cfgclk), .rst_n(rst_n), .cfg_soft_rst(cfg_soft_rst),
		.dsp_rst_req(dsp_rst_req), .seq_done(status.done),
		.cfg_resetn(cfg_resetn), .dsp_resetn(dsp_resetn)
	);

endmodule

// File: rtl/cfg_sequencer.sv
// step sequencer, plays the table out as four-phase device writes and delays.
`timescale 1ns/1ps

module cfg_sequencer import pl_cfg_pkg::*; #(
	parameter int ACK_TIMEOUT = 64
) (
	input  logic        cfgclk,
	input  logic        rst_n,
	input  logic        start,
	output logic [3:0]  step_ridx,
	input  cfg_step_t   step,
	output logic        tmr_load,
	output logic [15:0] tmr_count,
	input  logic        tmr_expired,
	output logic        dev_req,
	output dev_xfer_t   dev_xfer,
	input  logic        dev_ack,
	output cfg_status_t status
);

	localparam logic [15:0] ACK_CNT = 16'(ACK_TIMEOUT);

	seq_state_e state;
	logic       busy;
	logic       done;
	logic       error;
	logic [3:0] idx;
	logic       step_fin;

	// ******************************
	// timer and table control
	// ******************************

	assign step_ridx = idx;

	// decode loads delay or ack timeout.
	// ack seen reloads for the release wait.
	assign tmr_load  = (state == SEQ_DECODE) || (state == SEQ_REQ && dev_ack);
	assign tmr_count = (state == SEQ_DECODE && step.op == CFG_OP_DELAY) ?
		step.dev_data : ACK_CNT;

	// current step complete.
	assign step_fin = (state == SEQ_RELEASE && !dev_ack) ||
		(state == SEQ_DELAY && tmr_expired);

	// ******************************
	// state machine
	// ******************************

	always_ff @(posedge cfgclk) begin
		if (!rst_n) begin
			state   <= SEQ_IDLE;
			busy    <= 1'b0;
			done    <= 1'b0;
			error   <= 1'b0;
			idx     <= 4'd0;
			dev_req <= 1'b0;
		end else begin
			case (state)
				// start while busy is simply not looked at.
				SEQ_IDLE, SEQ_DONE, SEQ_ERROR: begin
					if (start) begin
						busy  <= 1'b1;
						done  <= 1'b0;
						error <= 1'b0;
						idx   <= 4'd0;
						state <= SEQ_FETCH;
					end
				end
				// table read in flight.
				SEQ_FETCH: begin
					state <= SEQ_DECODE;
				end
				SEQ_DECODE: begin
					case (step.op)
						CFG_OP_WRITE: begin
							dev_req <= 1'b1;
							state   <= SEQ_REQ;
						end
						CFG_OP_DELAY: begin
							state <= SEQ_DELAY;
						end
						// end, and the unused code.
						default: begin
							busy  <= 1'b0;
							done  <= 1'b1;
							state <= SEQ_DONE;
						end
					endcase
				end
				// wait ack high.
				SEQ_REQ: begin
					if (dev_ack) begin
						dev_req <= 1'b0;
						state   <= SEQ_RELEASE;
					end else if (tmr_expired) begin
						dev_req <= 1'b0;
						busy    <= 1'b0;
						error   <= 1'b1;
						state   <= SEQ_ERROR;
					end
				end
				// ack low, or delay over.
				SEQ_RELEASE, SEQ_DELAY: begin
					if (step_fin) begin
						if (idx == 4'hf) begin
							busy  <= 1'b0;
							done  <= 1'b1;
							state <= SEQ_DONE;
						end else begin
							idx   <= idx + 4'd1;
							state <= SEQ_FETCH;
						end
					end else if (state == SEQ_RELEASE && tmr_expired) begin
						busy  <= 1'b0;
						error <= 1'b1;
						state <= SEQ_ERROR;
					end
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	// payload, stable for the whole req phase.
	always_ff @(posedge cfgclk) begin
		if (state == SEQ_DECODE && step.op == CFG_OP_WRITE) begin
			dev_xfer.dev_addr <= step.dev_addr;
			dev_xfer.dev_data <= step.dev_data;
		end
	end

	assign status = '{busy: busy, done: done, error: error, step_idx: idx};

endmodule

// File: rtl/lb_cfg_regs.sv
// local bus decoder with control, status and scratch registers and read mux.
`timescale 1ns/1ps

module lb_cfg_regs import pl_cfg_pkg::*; (
	input  logic        cfgclk,
	input  logic        rst_n,
	input  lb_req_t     lb_req,
	output lb_rsp_t     lb_rsp,
	input  cfg_status_t status,
	output logic        start,
	output logic        cfg_soft_rst,
	output logic        dsp_rst_req,
	output logic        tbl_we,
	output logic [3:0]  tbl_widx,
	output cfg_step_t   tbl_wdata,
	output logic [3:0]  tbl_ridx,
	input  cfg_step_t   tbl_rdata
);

	// ******************************
	// address decode
	// ******************************

	logic        ctrl_hit;
	logic        status_hit;
	logic        scratch_hit;
	logic        tbl_hit;
	logic [31:0] scratch;
	logic [31:0] reg_rdata;
	logic [31:0] reg_rdata_q;
	logic        tbl_sel_q;
	logic        rvalid_q;

	assign ctrl_hit    = (lb_req.addr == REG_CTRL);
	assign status_hit  = (lb_req.addr == REG_STATUS);
	assign scratch_hit = (lb_req.addr == REG_SCRATCH);
	// 0x100..0x13c, word aligned only.
	assign tbl_hit     = (lb_req.addr[9:6] == STEP_BASE[9:6]) && (lb_req.addr[1:0] == 2'b00);

	// table port, straight from the bus.
	assign tbl_we    = lb_req.wr && tbl_hit;
	assign tbl_widx  = lb_req.addr[5:2];
	assign tbl_wdata = cfg_step_t'(lb_req.wdata);
	assign tbl_ridx  = lb_req.addr[5:2];

	// ******************************
	// control registers
	// ******************************

	// start is a one cycle pulse, never stored.
	always_ff @(posedge cfgclk) begin
		if (!rst_n) begin
			start        <= 1'b0;
			cfg_soft_rst <= 1'b0;
			dsp_rst_req  <= 1'b0;
		end else begin
			start <= lb_req.wr && ctrl_hit && lb_req.wdata[CTRL_START];
			if (lb_req.wr && ctrl_hit) begin
				cfg_soft_rst <= lb_req.wdata[CTRL_SOFT_RST];
				dsp_rst_req  <= lb_req.wdata[CTRL_DSP_RST];
			end
		end
	end

	// scratch.
	always_ff @(posedge cfgclk) begin
		if (lb_req.wr && scratch_hit) begin
			scratch <= lb_req.wdata;
		end
	end

	// ******************************
	// read path
	// ******************************

	// register side of the mux, unmapped reads 0.
	always_comb begin
		reg_rdata = 32'h0;
		if (ctrl_hit) begin
			reg_rdata[CTRL_SOFT_RST] = cfg_soft_rst;
			reg_rdata[CTRL_DSP_RST]  = dsp_rst_req;
		end else if (status_hit) begin
			reg_rdata[0]   = status.busy;
			reg_rdata[1]   = status.done;
			reg_rdata[2]   = status.error;
			reg_rdata[7:4] = status.step_idx;
		end else if (scratch_hit) begin
			reg_rdata = scratch;
		end
	end

	always_ff @(posedge cfgclk) begin
		if (!rst_n) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= lb_req.rd;
		end
	end

	// table data is already registered in the table.
	always_ff @(posedge cfgclk) begin
		reg_rdata_q <= reg_rdata;
		tbl_sel_q   <= tbl_hit;
	end

	assign lb_rsp.rvalid = rvalid_q;
	assign lb_rsp.rdata  = tbl_sel_q ? tbl_rdata : reg_rdata_q;

endmodule

// File: rtl/cfg_step_table.sv
// 16-entry step memory, one write port and two registered read ports.
`timescale 1ns/1ps

module cfg_step_table import pl_cfg_pkg::*; (
	input  logic       cfgclk,
	input  logic       we,
	input  logic [3:0] widx,
	input  cfg_step_t  wdata,
	input  logic [3:0] bus_ridx,
	output cfg_step_t  bus_rdata,
	input  logic [3:0] seq_ridx,
	output cfg_step_t  seq_rdata
);

	// ******************************
	// storage
	// ******************************

	// undefined until the host loads it.
	cfg_step_t mem [16];

	// write port.
	always_ff @(posedge cfgclk) begin
		if (we) begin
			mem[widx] <= wdata;
		end
	end

	// ******************************
	// read ports
	// ******************************

	// host side.
	// same-edge write returns the old word.
	always_ff @(posedge cfgclk) begin
		bus_rdata <= mem[bus_ridx];
	end

	// sequencer side.
	// index presented in fetch, word valid in decode.
	always_ff @(posedge cfgclk) begin
		seq_rdata <= mem[seq_ridx];
	end

endmodule

// File: rtl/reset_fanout.sv
// reset request logic with hold counters and registered wide reset replicas.
`timescale 1ns/1ps

module reset_fanout #(
	parameter int RESET_HOLD      = 16,
	parameter int CFG_RESET_WIDTH = 128,
	parameter int DSP_RESET_WIDTH = 32
) (
	input  logic                       cfgclk,
	input  logic                       rst_n,
	input  logic                       cfg_soft_rst,
	input  logic                       dsp_rst_req,
	input  logic                       seq_done,
	output logic [CFG_RESET_WIDTH-1:0] cfg_resetn,
	output logic [DSP_RESET_WIDTH-1:0] dsp_resetn
);

	localparam int HW = $clog2(RESET_HOLD + 1);

	// index 0 is the cfg domain and 1 the dsp domain.
	logic [1:0]    req;
	logic          cfg_up;
	logic [HW-1:0] hold [2];

	// dsp also waits for a finished sequence and a released cfg.
	assign req[0] = cfg_soft_rst;
	assign req[1] = dsp_rst_req || !seq_done || !cfg_up;

	// ******************************
	// hold counters and replicas
	// ******************************

	always_ff @(posedge cfgclk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2; i++) begin
				hold[i] <= HW'(RESET_HOLD);
			end
			cfg_up     <= 1'b0;
			cfg_resetn <= '0;
			dsp_resetn <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (req[i]) begin
					hold[i] <= HW'(RESET_HOLD);
				end else if (hold[i] != '0) begin
					hold[i] <= hold[i] - 1'b1;
				end
			end
			// local copy of the cfg release.
			cfg_up <= !req[0] && (hold[0] == '0);
			// assert one cycle after request.
			cfg_resetn <= {CFG_RESET_WIDTH{!req[0] && (hold[0] == '0)}};
			dsp_resetn <= {DSP_RESET_WIDTH{!req[1] && (hold[1] == '0)}};
		end
	end

endmodule

// File: rtl/settle_timer.sv
// loadable down-counter for delay steps and ack timeouts.
`timescale 1ns/1ps

module settle_timer (
	input  logic        cfgclk,
	input  logic        rst_n,
	input  logic        load,
	input  logic [15:0] count,
	output logic        expired
);

	logic [15:0] cnt;

	// ******************************
	// counter
	// ******************************

	// expired sticks until the next load.
	// load of n expires after n+1 edges.
	always_ff @(posedge cfgclk) begin
		if (!rst_n) begin
			cnt     <= 16'd0;
			expired <= 1'b0;
		end else if (load) begin
			cnt     <= count;
			expired <= 1'b0;
		end else if (!expired) begin
			if (cnt == 16'd0) begin
				expired <= 1'b1;
			end else begin
				cnt <= cnt - 16'd1;
			end
		end
	end

endmodule

// File: rtl/pl_cfg_pkg.sv
// configuration plane shared types, register map and state encodings.
package pl_cfg_pkg;

	// ******************************
	// local bus
	// ******************************

	// one cycle of host request.
	typedef struct packed {
		logic        wr;
		logic        rd;
		logic [9:0]  addr;
		logic [31:0] wdata;
	} lb_req_t;

	// read return, one cycle after rd.
	typedef struct packed {
		logic        rvalid;
		logic [31:0] rdata;
	} lb_rsp_t;

	// byte offsets.
	localparam logic [9:0] REG_CTRL    = 10'h000;
	localparam logic [9:0] REG_STATUS  = 10'h004;
	localparam logic [9:0] REG_SCRATCH = 10'h008;
	// step n at STEP_BASE + 4n.
	localparam logic [9:0] STEP_BASE   = 10'h100;

	// ctrl bit positions.
	localparam int CTRL_START    = 0;
	localparam int CTRL_SOFT_RST = 1;
	localparam int CTRL_DSP_RST  = 2;

	// ******************************
	// step table
	// ******************************

	// code 3 is not named, decodes as end.
	typedef enum logic [1:0] {
		CFG_OP_END   = 2'd0,
		CFG_OP_WRITE = 2'd1,
		CFG_OP_DELAY = 2'd2
	} cfg_op_e;

	// dev_data doubles as delay count.
	typedef struct packed {
		cfg_op_e     op;
		logic [5:0]  reserved;
		logic [7:0]  dev_addr;
		logic [15:0] dev_data;
	} cfg_step_t;

	// device write payload.
	typedef struct packed {
		logic [7:0]  dev_addr;
		logic [15:0] dev_data;
	} dev_xfer_t;

	typedef struct packed {
		logic       busy;
		logic       done;
		logic       error;
		logic [3:0] step_idx;
	} cfg_status_t;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_FETCH,
		SEQ_DECODE,
		SEQ_REQ,
		SEQ_RELEASE,
		SEQ_DELAY,
		SEQ_DONE,
		SEQ_ERROR
	} seq_state_e;

endpackage
